// ==== Makefile ====
VERILATOR ?= verilator
TOP       := store_queue_tb
FILELIST  := store_queue.f
FLAGS     := --binary --timing --timescale 1ns/1ps -Wno-fatal
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) store_queue_tb_vectors.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== sq_entry_array.sv ====
/*
 * Entry storage of the store queue with per-entry executed bits. Applies
 * retire clears, dispatch writes and execute updates, and offers the head
 * store to the data cache.
 */

`timescale 1ns/1ps

module sq_entry_array (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         flush,
    input  sq_types_pkg::sq_dispatch_t [sq_params_pkg::DISPATCH_WIDTH-1:0] dispatch,
    input  sq_types_pkg::sq_slot_t     [sq_params_pkg::DISPATCH_WIDTH-1:0] slots,
    input  sq_params_pkg::sq_idx_t       head,
    input  sq_params_pkg::retire_count_t retire_count,
    input  sq_types_pkg::sq_exec_t       exec_update,
    output sq_types_pkg::sq_entry_t    [sq_params_pkg::SQ_DEPTH-1:0] entries,
    output logic                         unexecuted_store,
    output sq_types_pkg::sq_dcache_store_t dcache_store
);

    // Next state of the array
    sq_types_pkg::sq_entry_t [sq_params_pkg::SQ_DEPTH-1:0] entries_next;

    // Set once the memory pipeline has supplied address and data
    logic [sq_params_pkg::SQ_DEPTH-1:0] executed;
    logic [sq_params_pkg::SQ_DEPTH-1:0] executed_next;

    // Entry at the head, the only one the cache may take
    sq_types_pkg::sq_entry_t head_entry;

    // ==================================================
    // Next-state update
    // ==================================================
    always_comb begin
        entries_next  = entries;
        executed_next = executed;

        // Retire first, freed slots may be refilled by dispatch below
        for (int i = 0; i < (1 << sq_params_pkg::RETIRE_COUNT_WIDTH); i++) begin
            if (retire_count > i) begin
                entries_next[sq_params_pkg::sq_idx_t'(head + i)].valid = 1'b0;
                executed_next[sq_params_pkg::sq_idx_t'(head + i)]      = 1'b0;
            end
        end

        // New stores, only the size is known at dispatch
        for (int lane = 0; lane < sq_params_pkg::DISPATCH_WIDTH; lane++) begin
            if (slots[lane].write) begin
                entries_next[slots[lane].idx].valid   = 1'b1;
                entries_next[slots[lane].idx].size    = dispatch[lane].size;
                entries_next[slots[lane].idx].address = '0;
                entries_next[slots[lane].idx].data    = '0;
                executed_next[slots[lane].idx]        = 1'b0;
            end
        end

        // Execute last, fills in address and data
        if (exec_update.valid) begin
            entries_next[exec_update.idx].address = exec_update.address;
            entries_next[exec_update.idx].data    = exec_update.data;
            executed_next[exec_update.idx]        = 1'b1;
        end
    end

    // ==================================================
    // State registers
    // ==================================================
    always_ff @(posedge clock) begin
        if (!reset || flush) begin
            // Mispredict or reset drops every store
            entries  <= '0;
            executed <= '0;
        end else begin
            entries  <= entries_next;
            executed <= executed_next;
        end
    end

    // ==================================================
    // Status outputs
    // ==================================================

    // Loads must wait while any store still lacks its address
    always_comb begin
        unexecuted_store = 1'b0;
        for (int i = 0; i < sq_params_pkg::SQ_DEPTH; i++) begin
            if (entries[i].valid && !executed[i]) begin
                unexecuted_store = 1'b1;
            end
        end
    end

    assign head_entry = entries[head];

    // Oldest store stays on the port until retire moves the head
    always_comb begin
        dcache_store = '0;
        if (head_entry.valid && executed[head]) begin
            dcache_store.valid   = 1'b1;
            dcache_store.size    = head_entry.size;
            dcache_store.address = head_entry.address;
            dcache_store.data    = head_entry.data;
        end
    end

endmodule

// ==== sq_forward_search.sv ====
/*
 * Store-to-load forwarding. Searches the stores older than the load from
 * youngest to oldest and returns the first one that covers the load's
 * byte address, with its data placed in the matching byte lane.
 */

`timescale 1ns/1ps

module sq_forward_search (
    input  sq_types_pkg::sq_entry_t [sq_params_pkg::SQ_DEPTH-1:0] entries,
    input  sq_params_pkg::sq_idx_t   head,
    input  sq_types_pkg::sq_lookup_t lookup,
    output sq_types_pkg::sq_forward_t forward
);

    // Stores between head and the load's tail
    sq_params_pkg::sq_idx_t older_count;

    // Entry examined at each step of the walk
    sq_params_pkg::sq_idx_t probe;

    // Youngest covering store already taken
    logic found;

    // ==================================================
    // Coverage and lane placement
    // ==================================================

    // True when the store writes the byte at addr
    function automatic logic covers(
        input sq_types_pkg::sq_entry_t entry,
        input sq_params_pkg::addr_t    addr
    );
        logic hit;
        hit = 1'b0;
        case (entry.size)
            sq_types_pkg::size_byte: hit = (entry.address == addr);
            // Half word ignores bit 0
            sq_types_pkg::size_half: begin
                hit = (entry.address[sq_params_pkg::ADDR_WIDTH-1:1]
                       == addr[sq_params_pkg::ADDR_WIDTH-1:1]);
            end
            // Word ignores bits 1:0
            sq_types_pkg::size_word: begin
                hit = (entry.address[sq_params_pkg::ADDR_WIDTH-1:2]
                       == addr[sq_params_pkg::ADDR_WIDTH-1:2]);
            end
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

    // Data as it sits in the 32-bit memory word, unused bytes zero
    function automatic sq_params_pkg::data_t place_data(
        input sq_types_pkg::sq_entry_t entry
    );
        sq_params_pkg::data_t placed;
        placed = '0;
        case (entry.size)
            sq_types_pkg::size_byte: begin
                placed = sq_params_pkg::data_t'(entry.data[7:0])
                         << {entry.address[1:0], 3'b000};
            end
            sq_types_pkg::size_half: begin
                if (entry.address[1]) begin
                    placed = {entry.data[15:0], 16'h0000};
                end else begin
                    placed = {16'h0000, entry.data[15:0]};
                end
            end
            default: placed = entry.data;
        endcase
        return placed;
    endfunction

    // ==================================================
    // Youngest-first walk
    // ==================================================
    always_comb begin
        forward = '0;
        found   = 1'b0;
        probe   = '0;

        // Tail equal to head leaves nothing older to search
        older_count = sq_params_pkg::sq_idx_t'(lookup.tail - head);

        for (int step = 0; step < sq_params_pkg::SQ_DEPTH; step++) begin
            // Step 0 is the store just before the load's tail
            probe = sq_params_pkg::sq_idx_t'(lookup.tail - 1 - step);
            if (lookup.valid && !found && (step < int'(older_count))) begin
                // Unexecuted stores are not skipped
                if (entries[probe].valid && covers(entries[probe], lookup.address)) begin
                    found        = 1'b1;
                    forward.hit  = 1'b1;
                    forward.data = place_data(entries[probe]);
                end
            end
        end
    end

endmodule

// ==== sq_params_pkg.sv ====
/*
 * Store queue sizing: queue depth, dispatch lanes and data path widths.
 * Other files refer to these by scoped names and never import the package.
 */

package sq_params_pkg;

    // ==================================================
    // Queue geometry
    // ==================================================

    // Entries in the circular store queue
    localparam int SQ_DEPTH = 8;

    // Stores accepted from dispatch per cycle
    localparam int DISPATCH_WIDTH = 2;

    // Index into the queue, wraps naturally at SQ_DEPTH
    localparam int SQ_IDX_WIDTH = 3;

    // Free count has to hold the full depth, so one extra bit
    localparam int SQ_COUNT_WIDTH = 4;

    // Entries freed by retire in one cycle
    localparam int RETIRE_COUNT_WIDTH = 2;

    // ==================================================
    // Memory data path
    // ==================================================
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // Width types used on ports and registers
    typedef logic [SQ_IDX_WIDTH-1:0]       sq_idx_t;
    typedef logic [SQ_COUNT_WIDTH-1:0]     sq_count_t;
    typedef logic [RETIRE_COUNT_WIDTH-1:0] retire_count_t;
    typedef logic [ADDR_WIDTH-1:0]         addr_t;
    typedef logic [DATA_WIDTH-1:0]         data_t;

endpackage

// ==== sq_pointers.sv ====
/*
 * Head, tail and free-count registers of the store queue. Packs the valid
 * dispatch lanes onto consecutive indices starting at the tail.
 */

`timescale 1ns/1ps

module sq_pointers (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          flush,
    input  sq_types_pkg::sq_dispatch_t [sq_params_pkg::DISPATCH_WIDTH-1:0] dispatch,
    input  sq_params_pkg::retire_count_t  retire_count,
    output sq_params_pkg::sq_idx_t        head,
    output sq_params_pkg::sq_idx_t        tail,
    output sq_params_pkg::sq_count_t      free_slots,
    output sq_params_pkg::sq_idx_t   [sq_params_pkg::DISPATCH_WIDTH-1:0] alloc_idx,
    output sq_types_pkg::sq_slot_t   [sq_params_pkg::DISPATCH_WIDTH-1:0] slots
);

    // Valid lanes seen so far, ends as the dispatch count for the cycle
    sq_params_pkg::sq_count_t lanes_used;

    // ==================================================
    // Lane placement
    // ==================================================
    always_comb begin
        lanes_used = '0;
        for (int lane = 0; lane < sq_params_pkg::DISPATCH_WIDTH; lane++) begin
            // Offered index, independent of the lane's valid bit
            alloc_idx[lane] = sq_params_pkg::sq_idx_t'(tail + lane);

            // Valid lanes are packed with no holes left by idle lanes
            slots[lane].write = dispatch[lane].valid;
            slots[lane].idx   = sq_params_pkg::sq_idx_t'(tail + lanes_used);
            if (dispatch[lane].valid) begin
                lanes_used = lanes_used + 1'b1;
            end
        end
    end

    // ==================================================
    // Pointer registers
    // ==================================================
    always_ff @(posedge clock) begin
        if (!reset || flush) begin
            // Empty queue, both pointers back at entry 0
            head       <= '0;
            tail       <= '0;
            free_slots <= sq_params_pkg::sq_count_t'(sq_params_pkg::SQ_DEPTH);
        end else begin
            // Index width matches depth, so truncation is the wrap
            head <= sq_params_pkg::sq_idx_t'(head + retire_count);
            tail <= sq_params_pkg::sq_idx_t'(tail + lanes_used);

            // Retire and dispatch in the same cycle net out
            free_slots <= free_slots
                        + sq_params_pkg::sq_count_t'(retire_count)
                        - lanes_used;
        end
    end

endmodule

// ==== sq_types_pkg.sv ====
/*
 * Access sizes and the packed structs that carry store queue entries and
 * the dispatch, execute, lookup, forward and cache port groups.
 */

package sq_types_pkg;

    // ==================================================
    // Access size
    // ==================================================

    // Byte, half word and word stores; 32-bit data has no double
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    // ==================================================
    // Stored state
    // ==================================================

    // One queue entry, address and data filled in at execute
    typedef struct packed {
        logic                 valid;
        mem_size_t            size;
        sq_params_pkg::addr_t address;
        sq_params_pkg::data_t data;
    } sq_entry_t;

    // ==================================================
    // Port groups
    // ==================================================

    // One dispatch lane, only the size is known this early
    typedef struct packed {
        logic      valid;
        mem_size_t size;
    } sq_dispatch_t;

    // Entry that a dispatch lane lands in
    typedef struct packed {
        logic                   write;
        sq_params_pkg::sq_idx_t idx;
    } sq_slot_t;

    // Address and data from the memory pipeline
    typedef struct packed {
        logic                   valid;
        sq_params_pkg::sq_idx_t idx;
        sq_params_pkg::addr_t   address;
        sq_params_pkg::data_t   data;
    } sq_exec_t;

    // Load lookup; tail is the queue tail captured at load dispatch
    typedef struct packed {
        logic                   valid;
        sq_params_pkg::addr_t   address;
        sq_params_pkg::sq_idx_t tail;
    } sq_lookup_t;

    // Forwarded data, already placed in its byte lane
    typedef struct packed {
        logic                 hit;
        sq_params_pkg::data_t data;
    } sq_forward_t;

    // Oldest store, held until retire frees it
    typedef struct packed {
        logic                 valid;
        mem_size_t            size;
        sq_params_pkg::addr_t address;
        sq_params_pkg::data_t data;
    } sq_dcache_store_t;

endpackage

// ==== store_queue.f ====
+incdir+.
sq_params_pkg.sv
sq_types_pkg.sv
sq_pointers.sv
sq_entry_array.sv
sq_forward_search.sv
store_queue.sv
store_queue_tb.sv

// ==== store_queue.sv ====
/*
 * Store queue top level. Connects the pointer block, the entry array and
 * the forwarding search, and brings their ports out to the core.
 */

`timescale 1ns/1ps

module store_queue (
    input  logic clock,
    input  logic reset,
    input  logic flush,

    // ==================================================
    // Dispatch
    // ==================================================
    input  sq_types_pkg::sq_dispatch_t [sq_params_pkg::DISPATCH_WIDTH-1:0] dispatch,
    output sq_params_pkg::sq_count_t   free_slots,
    output sq_params_pkg::sq_idx_t     [sq_params_pkg::DISPATCH_WIDTH-1:0] alloc_idx,
    // Current tail, captured by loads for the forwarding lookup
    output sq_params_pkg::sq_idx_t     sq_tail,

    // ==================================================
    // Memory pipeline
    // ==================================================
    input  sq_types_pkg::sq_exec_t     exec_update,
    input  sq_types_pkg::sq_lookup_t   lookup,
    output sq_types_pkg::sq_forward_t  forward,
    output logic                       unexecuted_store,

    // ==================================================
    // Retire and data cache
    // ==================================================
    input  sq_params_pkg::retire_count_t   retire_count,
    output sq_types_pkg::sq_dcache_store_t dcache_store
);

    // Pointers shared by the entry array and the search
    sq_params_pkg::sq_idx_t head;
    sq_params_pkg::sq_idx_t tail;

    // Target entry of each dispatch lane
    sq_types_pkg::sq_slot_t [sq_params_pkg::DISPATCH_WIDTH-1:0] slots;

    // Entry contents read by the forwarding search
    sq_types_pkg::sq_entry_t [sq_params_pkg::SQ_DEPTH-1:0] entries;

    sq_pointers u_pointers (
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .dispatch     (dispatch),
        .retire_count (retire_count),
        .head         (head),
        .tail         (tail),
        .free_slots   (free_slots),
        .alloc_idx    (alloc_idx),
        .slots        (slots)
    );

    sq_entry_array u_entry_array (
        .clock            (clock),
        .reset            (reset),
        .flush            (flush),
        .dispatch         (dispatch),
        .slots            (slots),
        .head             (head),
        .retire_count     (retire_count),
        .exec_update      (exec_update),
        .entries          (entries),
        .unexecuted_store (unexecuted_store),
        .dcache_store     (dcache_store)
    );

    sq_forward_search u_forward_search (
        .entries (entries),
        .head    (head),
        .lookup  (lookup),
        .forward (forward)
    );

    assign sq_tail = tail;

endmodule

// ==== store_queue_tb_vectors.svh ====
/*
 * Step table for the store queue testbench, included inside the testbench
 * module. Each row is driven for one cycle, and its expected values describe
 * that same cycle, with the registers holding the effect of all earlier rows.
 */

`ifndef STORE_QUEUE_TB_VECTORS_SVH
`define STORE_QUEUE_TB_VECTORS_SVH

// Each row holds the stimulus first and then the expected outputs
typedef struct packed {
    logic [8*12-1:0]                  name;
    sq_types_pkg::sq_dispatch_t [1:0] dispatch;
    sq_types_pkg::sq_exec_t           exec_update;
    sq_params_pkg::retire_count_t     retire_count;
    sq_types_pkg::sq_lookup_t         lookup;
    logic                             flush;
    sq_params_pkg::sq_count_t         exp_free;
    sq_params_pkg::sq_idx_t           exp_alloc;
    logic                             exp_unexecuted;
    sq_types_pkg::sq_dcache_store_t   exp_dcache;
    sq_types_pkg::sq_forward_t        exp_forward;
} step_t;

step_t steps[$];

task automatic add_step(
    input logic [8*12-1:0] name,
    input sq_types_pkg::sq_dispatch_t d0, d1,
    input sq_types_pkg::sq_exec_t ex,
    input sq_params_pkg::retire_count_t ret,
    input sq_types_pkg::sq_lookup_t lk,
    input logic fl,
    input sq_params_pkg::sq_count_t free,
    input sq_params_pkg::sq_idx_t alloc,
    input logic unexec,
    input sq_types_pkg::sq_dcache_store_t dcs,
    input sq_types_pkg::sq_forward_t fwd
);
    step_t s;
    s = '{name, {d1, d0}, ex, ret, lk, fl, free, alloc, unexec, dcs, fwd};
    steps.push_back(s);
endtask

// Columns are name, lane 0, lane 1, update, retire, lookup and flush,
// then free_slots, alloc_idx[0], unexecuted_store, dcache_store and forward
task automatic fill_steps();
    // Dispatch and execute with the head not yet executed
    add_step("reset", DISP_WORD, DISP_WORD, '0, 2'd0, '0, 1'b0, 4'd8, 3'd0, 1'b0, '0, '0);
    add_step("lane1_only", DISP_NONE, DISP_HALF, '0, 2'd0, '0, 1'b0, 4'd6, 3'd2, 1'b1, '0, '0);
    add_step("exec_mid", DISP_NONE, DISP_NONE, exec_at(3'd1, 32'h0000_1004, 32'h2222_2222),
             2'd0, '0, 1'b0, 4'd5, 3'd3, 1'b1, '0, '0);
    add_step("exec_half", DISP_NONE, DISP_NONE, exec_at(3'd2, 32'h0000_100a, 32'h0000_beef),
             2'd0, '0, 1'b0, 4'd5, 3'd3, 1'b1, '0, '0);
    add_step("exec_head", DISP_NONE, DISP_NONE, exec_at(3'd0, 32'h0000_1000, 32'h1111_1111),
             2'd0, '0, 1'b0, 4'd5, 3'd3, 1'b1, '0, '0);

    // Forwarding against entries 0 to 2 with the head word on the cache port
    add_step("fwd_half", DISP_NONE, DISP_NONE, '0, 2'd0, lookup_at(32'h0000_100b, 3'd3), 1'b0,
             4'd5, 3'd3, 1'b0, HEAD_WORD, forwarded(32'hbeef_0000));
    add_step("fwd_word", DISP_NONE, DISP_NONE, '0, 2'd0, lookup_at(32'h0000_1006, 3'd3), 1'b0,
             4'd5, 3'd3, 1'b0, HEAD_WORD, forwarded(32'h2222_2222));
    add_step("fwd_miss", DISP_NONE, DISP_NONE, '0, 2'd0, lookup_at(32'h0000_2000, 3'd3), 1'b0,
             4'd5, 3'd3, 1'b0, HEAD_WORD, '0);
    add_step("fwd_empty", DISP_NONE, DISP_NONE, '0, 2'd0, lookup_at(32'h0000_1000, 3'd0), 1'b0,
             4'd5, 3'd3, 1'b0, HEAD_WORD, '0);
    add_step("fwd_younger", DISP_NONE, DISP_NONE, '0, 2'd0, lookup_at(32'h0000_1004, 3'd1),
             1'b0, 4'd5, 3'd3, 1'b0, HEAD_WORD, '0);

    // Retiring two makes the half store at entry 2 the head
    add_step("retire2", DISP_NONE, DISP_NONE, '0, 2'd2, '0, 1'b0,
             4'd5, 3'd3, 1'b0, HEAD_WORD, '0);
    add_step("disp_pair", DISP_WORD, DISP_BYTE, '0, 2'd0, '0, 1'b0,
             4'd7, 3'd3, 1'b0, HEAD_HALF, '0);
    add_step("exec_word", DISP_NONE, DISP_NONE, exec_at(3'd3, 32'h0000_2000, 32'haabb_ccdd),
             2'd0, '0, 1'b0, 4'd5, 3'd5, 1'b1, HEAD_HALF, '0);
    add_step("exec_byte", DISP_NONE, DISP_NONE, exec_at(3'd4, 32'h0000_2001, 32'h0000_0077),
             2'd0, '0, 1'b0, 4'd5, 3'd5, 1'b1, HEAD_HALF, '0);
    add_step("fwd_byte", DISP_NONE, DISP_NONE, '0, 2'd0, lookup_at(32'h0000_2001, 3'd5), 1'b0,
             4'd5, 3'd5, 1'b0, HEAD_HALF, forwarded(32'h0000_7700));
    add_step("fwd_word2", DISP_NONE, DISP_NONE, '0, 2'd0, lookup_at(32'h0000_2003, 3'd5), 1'b0,
             4'd5, 3'd5, 1'b0, HEAD_HALF, forwarded(32'haabb_ccdd));

    // Tail wraps past 7 and the head moves to entry 5 while one store enters
    add_step("disp_wrap1", DISP_WORD, DISP_WORD, '0, 2'd0, '0, 1'b0,
             4'd5, 3'd5, 1'b0, HEAD_HALF, '0);
    add_step("disp_wrap2", DISP_BYTE, DISP_HALF, '0, 2'd0, '0, 1'b0,
             4'd3, 3'd7, 1'b1, HEAD_HALF, '0);
    add_step("retire_wrap", DISP_WORD, DISP_NONE, '0, 2'd3, '0, 1'b0,
             4'd1, 3'd1, 1'b1, HEAD_HALF, '0);
    add_step("exec_wrap", DISP_NONE, DISP_NONE, exec_at(3'd5, 32'h0000_3000, 32'h5555_5555),
             2'd0, '0, 1'b0, 4'd3, 3'd2, 1'b1, '0, '0);
    add_step("exec_zero", DISP_NONE, DISP_NONE, exec_at(3'd0, 32'h0000_3010, 32'h0000_1234),
             2'd0, '0, 1'b0, 4'd3, 3'd2, 1'b1, WRAP_WORD, '0);

    // Flush in mid-run
    add_step("flush", DISP_NONE, DISP_NONE, '0, 2'd0, '0, 1'b1,
             4'd3, 3'd2, 1'b1, WRAP_WORD, '0);
    add_step("after_flush", DISP_NONE, DISP_NONE, '0, 2'd0, lookup_at(32'h0000_3010, 3'd1),
             1'b0, 4'd8, 3'd0, 1'b0, '0, '0);
endtask

`endif

// ==== store_queue_tb.sv ====
/*
 * Testbench for the store queue. Applies the included step table one row
 * per cycle and compares every output with the row's expected values.
 */

`timescale 1ns/1ps

module store_queue_tb;

    logic                           clock;
    logic                           reset;
    logic                           flush;
    sq_types_pkg::sq_dispatch_t     [sq_params_pkg::DISPATCH_WIDTH-1:0] dispatch;
    sq_types_pkg::sq_exec_t         exec_update;
    sq_params_pkg::retire_count_t   retire_count;
    sq_types_pkg::sq_lookup_t       lookup;
    sq_params_pkg::sq_count_t       free_slots;
    sq_params_pkg::sq_idx_t         [sq_params_pkg::DISPATCH_WIDTH-1:0] alloc_idx;
    sq_params_pkg::sq_idx_t         sq_tail;
    logic                           unexecuted_store;
    sq_types_pkg::sq_forward_t      forward;
    sq_types_pkg::sq_dcache_store_t dcache_store;

    // Watchdog state, limit set once the table is built
    int cycle_count = 0;
    int cycle_limit = 0;

    // ==================================================
    // Table shorthands
    // ==================================================
    localparam sq_types_pkg::sq_dispatch_t DISP_NONE = '0;
    localparam sq_types_pkg::sq_dispatch_t DISP_BYTE = '{1'b1, sq_types_pkg::size_byte};
    localparam sq_types_pkg::sq_dispatch_t DISP_HALF = '{1'b1, sq_types_pkg::size_half};
    localparam sq_types_pkg::sq_dispatch_t DISP_WORD = '{1'b1, sq_types_pkg::size_word};

    // Head stores expected on the cache port, data as stored
    localparam sq_types_pkg::sq_dcache_store_t HEAD_WORD =
        '{1'b1, sq_types_pkg::size_word, 32'h0000_1000, 32'h1111_1111};
    localparam sq_types_pkg::sq_dcache_store_t HEAD_HALF =
        '{1'b1, sq_types_pkg::size_half, 32'h0000_100a, 32'h0000_beef};
    localparam sq_types_pkg::sq_dcache_store_t WRAP_WORD =
        '{1'b1, sq_types_pkg::size_word, 32'h0000_3000, 32'h5555_5555};

    function automatic sq_types_pkg::sq_exec_t exec_at(
        input sq_params_pkg::sq_idx_t idx,
        input sq_params_pkg::addr_t   address,
        input sq_params_pkg::data_t   data
    );
        return '{1'b1, idx, address, data};
    endfunction

    function automatic sq_types_pkg::sq_lookup_t lookup_at(
        input sq_params_pkg::addr_t   address,
        input sq_params_pkg::sq_idx_t tail
    );
        return '{1'b1, address, tail};
    endfunction

    function automatic sq_types_pkg::sq_forward_t forwarded(input sq_params_pkg::data_t data);
        return '{1'b1, data};
    endfunction

    `include "store_queue_tb_vectors.svh"

    store_queue DUT (
        .clock            (clock),
        .reset            (reset),
        .flush            (flush),
        .dispatch         (dispatch),
        .free_slots       (free_slots),
        .alloc_idx        (alloc_idx),
        .sq_tail          (sq_tail),
        .exec_update      (exec_update),
        .lookup           (lookup),
        .forward          (forward),
        .unexecuted_store (unexecuted_store),
        .retire_count     (retire_count),
        .dcache_store     (dcache_store)
    );

    // 4 ns period
    always #2 clock = ~clock;

    // Watchdog
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("TEST FAIL");
            $fatal(1, "Timeout: the step table did not finish within %0d cycles", cycle_limit);
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    task automatic check_value(
        input logic [8*12-1:0] step_name,
        input string           field,
        input logic [71:0]     expected,
        input logic [71:0]     actual
    );
        if (expected !== actual) begin
            $display("Mismatch in %s: %s expected %h actual %h",
                     step_name, field, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_step(input step_t s);
        sq_params_pkg::sq_idx_t next_idx;
        // Lane 1 is always offered the tail plus one
        next_idx = s.exp_alloc + 3'd1;
        check_value(s.name, "free_slots", s.exp_free, free_slots);
        check_value(s.name, "alloc_idx[0]", s.exp_alloc, alloc_idx[0]);
        check_value(s.name, "alloc_idx[1]", next_idx, alloc_idx[1]);
        check_value(s.name, "sq_tail", s.exp_alloc, sq_tail);
        check_value(s.name, "unexecuted_store", s.exp_unexecuted, unexecuted_store);
        check_value(s.name, "dcache_store", s.exp_dcache, dcache_store);
        check_value(s.name, "forward", s.exp_forward, forward);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        clock        = 1'b0;
        reset        = 1'b0;
        flush        = 1'b0;
        dispatch     = '0;
        exec_update  = '0;
        retire_count = '0;
        lookup       = '0;
        fill_steps();
        cycle_limit = steps.size() + 20;

        repeat (3) @(posedge clock);
        reset <= 1'b1;

        foreach (steps[i]) begin
            @(posedge clock);
            flush        <= steps[i].flush;
            dispatch     <= steps[i].dispatch;
            exec_update  <= steps[i].exec_update;
            retire_count <= steps[i].retire_count;
            lookup       <= steps[i].lookup;
            // Registers and lookup result settled by the falling edge
            @(negedge clock);
            check_step(steps[i]);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
